//--- bench/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb import rvPkg::*; ();

    localparam int clkPeriod   = 20;
    localparam int testCycles  = 300;
    localparam int numTests    = 5;
    localparam int waitLimit   = 280;
    localparam int drainCycles = 10;
    localparam int driveDelay  = 2;

    logic        clk = 1'b0;
    logic        rstN;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic        wbEn;
    logic [4:0]  wbRd;
    logic [31:0] wbData;

    logic [31:0] rom [1024];
    logic [31:0] prog [$];
    logic [4:0]  expRd [$];
    logic [31:0] expVal [$];
    logic [4:0]  gotRd [$];
    logic [31:0] gotVal [$];
    integer      seed = 32'hee76_1e31;

    always #(clkPeriod / 2) clk = ~clk;

    cpuTop dut_i (
        .clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
        .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData)
    );

    // instruction memory answers in the same cycle
    assign imemData = rom[imemAddr[11:2]];

    always @(negedge clk) begin
        if (rstN && wbEn) begin
            gotRd.push_back(wbRd);
            gotVal.push_back(wbData);
        end
    end

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] instr);
        prog.push_back(instr);
    endtask

    task automatic expectWrite(input logic [4:0] rd, input logic [31:0] val);
        expRd.push_back(rd);
        expVal.push_back(val);
    endtask

    task automatic clearRom();
        for (int i = 0; i < 1024; i++) begin
            rom[i] = nopInstr;
        end
    endtask

    task automatic runProgram(input string name);
        int cycles;
        @(posedge clk);
        #driveDelay;
        rstN = 1'b0;
        clearRom();
        foreach (prog[i]) begin
            rom[i] = prog[i];
        end
        repeat (5) @(posedge clk);
        #driveDelay;
        gotRd.delete();
        gotVal.delete();
        rstN = 1'b1;
        cycles = 0;
        while (gotRd.size() < expRd.size() && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
        end
        assert (gotRd.size() >= expRd.size()) else begin
            $display("error: %s timed out after %0d cycles with %0d of %0d writebacks",
                     name, cycles, gotRd.size(), expRd.size());
            $display("TESTS FAILED");
            $fatal(1, "writeback timeout");
        end
        // late extra writebacks would mean a flushed instruction retired
        repeat (drainCycles) @(posedge clk);
        assert (gotRd.size() == expRd.size()) else begin
            $display("error: %s writeback count expected %0d actual %0d",
                     name, expRd.size(), gotRd.size());
            $display("TESTS FAILED");
            $fatal(1, "writeback count");
        end
        foreach (expRd[i]) begin
            assert (gotRd[i] == expRd[i] && gotVal[i] === expVal[i]) else begin
                $display("error: %s writeback %0d expected x%0d=%h actual x%0d=%h",
                         name, i, expRd[i], expVal[i], gotRd[i], gotVal[i]);
                $display("TESTS FAILED");
                $fatal(1, "writeback mismatch");
            end
        end
        prog.delete();
        expRd.delete();
        expVal.delete();
    endtask

    task automatic aluChain();
        logic [31:0] r;
        logic [11:0] immA;
        logic [11:0] immB;
        logic [31:0] a, b, c, d, e, h;
        r = $random(seed);
        immA = r[11:0];
        r = $random(seed);
        immB = r[11:0];
        a = sext12(immA);
        b = sext12(immB);
        c = a + b;
        d = c - a;
        e = d ^ c;
        h = $signed(e) >>> b[4:0];
        emit(iType(immA, 5'd0, 3'b000, 5'd1, opImm));
        emit(iType(immB, 5'd0, 3'b000, 5'd2, opImm));
        // x2 from MEM and x1 from WB
        emit(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit(rType(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        emit(rType(7'h00, 5'd3, 5'd4, 3'b100, 5'd5));
        emit(rType(7'h00, 5'd4, 5'd5, 3'b010, 5'd6));
        emit(rType(7'h00, 5'd5, 5'd4, 3'b011, 5'd7));
        emit(rType(7'h20, 5'd2, 5'd5, 3'b101, 5'd8));
        emit(rType(7'h00, 5'd1, 5'd8, 3'b001, 5'd9));
        expectWrite(5'd1, a);
        expectWrite(5'd2, b);
        expectWrite(5'd3, c);
        expectWrite(5'd4, d);
        expectWrite(5'd5, e);
        expectWrite(5'd6, {31'b0, $signed(e) < $signed(d)});
        expectWrite(5'd7, {31'b0, d < e});
        expectWrite(5'd8, h);
        expectWrite(5'd9, h << a[4:0]);
        runProgram("aluChain");
    endtask

    task automatic loadStore();
        logic [31:0] r;
        logic [19:0] hiW;
        logic [11:0] loW;
        logic [31:0] w;
        r = $random(seed);
        hiW = {r[19:4], 4'h0};
        // bits 15 and 7 of the word end up set
        loW = r[31:20] | 12'h880;
        w = {hiW, 12'h000} + sext12(loW);
        emit(iType(12'h100, 5'd0, 3'b000, 5'd10, opImm));
        emit(uType(hiW, 5'd11, opLui));
        emit(iType(loW, 5'd11, 3'b000, 5'd11, opImm));
        emit(sType(12'd0, 5'd11, 5'd10, 3'b010));
        emit(sType(12'd6, 5'd11, 5'd10, 3'b001));
        emit(sType(12'd9, 5'd11, 5'd10, 3'b000));
        emit(iType(12'd6, 5'd10, 3'b001, 5'd12, opLoad));
        emit(iType(12'd1, 5'd12, 3'b000, 5'd13, opImm));
        emit(iType(12'd6, 5'd10, 3'b101, 5'd14, opLoad));
        emit(iType(12'd1, 5'd14, 3'b000, 5'd15, opImm));
        emit(iType(12'd9, 5'd10, 3'b000, 5'd16, opLoad));
        emit(iType(12'd1, 5'd16, 3'b000, 5'd17, opImm));
        emit(iType(12'd9, 5'd10, 3'b100, 5'd18, opLoad));
        emit(iType(12'd1, 5'd18, 3'b000, 5'd19, opImm));
        emit(iType(12'd0, 5'd10, 3'b010, 5'd20, opLoad));
        emit(iType(12'd1, 5'd20, 3'b000, 5'd21, opImm));
        expectWrite(5'd10, 32'h100);
        expectWrite(5'd11, {hiW, 12'h000});
        expectWrite(5'd11, w);
        expectWrite(5'd12, {{16{w[15]}}, w[15:0]});
        expectWrite(5'd13, {{16{w[15]}}, w[15:0]} + 32'd1);
        expectWrite(5'd14, {16'h0, w[15:0]});
        expectWrite(5'd15, {16'h0, w[15:0]} + 32'd1);
        expectWrite(5'd16, {{24{w[7]}}, w[7:0]});
        expectWrite(5'd17, {{24{w[7]}}, w[7:0]} + 32'd1);
        expectWrite(5'd18, {24'h0, w[7:0]});
        expectWrite(5'd19, {24'h0, w[7:0]} + 32'd1);
        expectWrite(5'd20, w);
        expectWrite(5'd21, w + 32'd1);
        runProgram("loadStore");
    endtask

    task automatic branches();
        logic [31:0] r;
        logic [11:0] immN;
        logic [11:0] immP;
        logic [31:0] regVal [32];
        logic [2:0]  f3 [12];
        logic [4:0]  rsA [12];
        logic [4:0]  rsB [12];
        r = $random(seed);
        immN = {1'b1, r[10:0]};
        immP = {1'b0, r[26:16]};
        regVal[1] = sext12(immN);
        regVal[2] = sext12(immP);
        regVal[3] = regVal[1];
        // x1 negative, x2 positive, x3 a copy of x1
        f3  = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4, 3'd5, 3'd5, 3'd6, 3'd6, 3'd7, 3'd7};
        rsA = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
        rsB = '{5'd3, 5'd2, 5'd2, 5'd3, 5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
        emit(iType(immN, 5'd0, 3'b000, 5'd1, opImm));
        emit(iType(immP, 5'd0, 3'b000, 5'd2, opImm));
        emit(iType(12'd0, 5'd1, 3'b000, 5'd3, opImm));
        expectWrite(5'd1, regVal[1]);
        expectWrite(5'd2, regVal[2]);
        expectWrite(5'd3, regVal[3]);
        for (int i = 0; i < 12; i++) begin
            // taken skips both x30 markers
            emit(bType(13'd12, rsB[i], rsA[i], f3[i]));
            emit(iType(12'(i + 1), 5'd0, 3'b000, 5'd30, opImm));
            emit(iType(12'(i + 1), 5'd0, 3'b000, 5'd30, opImm));
            emit(iType(12'(i + 1), 5'd0, 3'b000, 5'd29, opImm));
            if (!branchTaken(f3[i], regVal[rsA[i]], regVal[rsB[i]])) begin
                expectWrite(5'd30, 32'(i + 1));
                expectWrite(5'd30, 32'(i + 1));
            end
            expectWrite(5'd29, 32'(i + 1));
        end
        runProgram("branches");
    endtask

    task automatic jumps();
        logic [31:0] r;
        logic [19:0] luiImm;
        logic [19:0] auiImm;
        logic [31:0] here;
        r = $random(seed);
        luiImm = r[19:0];
        auiImm = r[31:12];
        emit(uType(luiImm, 5'd1, opLui));
        expectWrite(5'd1, {luiImm, 12'h000});
        here = 32'(prog.size() * 4);
        emit(uType(auiImm, 5'd2, opAuipc));
        expectWrite(5'd2, here + {auiImm, 12'h000});
        here = 32'(prog.size() * 4);
        emit(jType(21'd16, 5'd3));
        expectWrite(5'd3, here + 32'd4);
        for (int i = 1; i <= 3; i++) begin
            emit(iType(12'(i), 5'd0, 3'b000, 5'd31, opImm));
        end
        emit(iType(12'd48, 5'd0, 3'b000, 5'd4, opImm));
        expectWrite(5'd4, 32'd48);
        // 48 + 5 with bit 0 cleared lands on 52
        here = 32'(prog.size() * 4);
        emit(iType(12'd5, 5'd4, 3'b000, 5'd5, opJalr));
        expectWrite(5'd5, here + 32'd4);
        emit(iType(12'd4, 5'd0, 3'b000, 5'd31, opImm));
        emit(iType(12'd5, 5'd0, 3'b000, 5'd31, opImm));
        repeat (3) emit(nopInstr);
        here = 32'(prog.size() * 4);
        emit(uType(20'h0, 5'd6, opAuipc));
        expectWrite(5'd6, here);
        runProgram("jumps");
    endtask

    task automatic zeroReg();
        logic [31:0] r;
        logic [11:0] immR;
        r = $random(seed);
        immR = r[11:0];
        emit(iType(12'd55, 5'd0, 3'b000, 5'd0, opImm));
        emit(iType(immR, 5'd0, 3'b000, 5'd1, opImm));
        emit(rType(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        emit(uType(r[31:12], 5'd0, opLui));
        emit(rType(7'h00, 5'd0, 5'd1, 3'b000, 5'd2));
        emit(rType(7'h00, 5'd1, 5'd0, 3'b000, 5'd3));
        expectWrite(5'd1, sext12(immR));
        expectWrite(5'd2, sext12(immR));
        expectWrite(5'd3, sext12(immR));
        runProgram("zeroReg");
    endtask

    initial begin
        rstN = 1'b0;
        clearRom();
        aluChain();
        loadStore();
        branches();
        jumps();
        zeroReg();
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        #(numTests * testCycles * clkPeriod);
        $display("error: watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $fatal(1, "watchdog");
    end

endmodule

`default_nettype wire

//--- common/rvPkg.sv
`default_nettype none

package rvPkg;

    // major opcodes
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOpT;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        fwdNone,
        fwdMem,
        fwdWb
    } fwdSelT;

    typedef enum logic [1:0] {
        aSrcReg,
        aSrcPc,
        aSrcZero
    } aSrcT;

    localparam int dmemWords = 256;

    // addi x0, x0, 0
    localparam logic [31:0] nopInstr = 32'h0000_0013;

endpackage

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rvPkg::*; (
    input  logic [31:0] rs1Val,
    input  logic [31:0] rs2Val,
    input  logic [31:0] memFwd,
    input  logic [31:0] wbFwd,
    input  logic [31:0] pc,
    input  logic [31:0] imm,
    input  fwdSelT      fwdA,
    input  fwdSelT      fwdB,
    input  aSrcT        aSrc,
    input  logic        bSrcImm,
    input  aluOpT       aluOp,
    output logic [31:0] result,
    output logic [31:0] fwdRs1,
    output logic [31:0] fwdRs2
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [4:0]  shamt;

    function automatic logic [31:0] fwdMux(input fwdSelT sel, input logic [31:0] regVal,
                                           input logic [31:0] memVal,
                                           input logic [31:0] wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign fwdRs1 = fwdMux(fwdA, rs1Val, memFwd, wbFwd);
    assign fwdRs2 = fwdMux(fwdB, rs2Val, memFwd, wbFwd);

    always_comb begin
        case (aSrc)
            aSrcPc:   opA = pc;
            aSrcZero: opA = '0;
            default:  opA = fwdRs1;
        endcase
    end

    assign opB   = bSrcImm ? imm : fwdRs2;
    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            aluAdd:   result = opA + opB;
            aluSub:   result = opA - opB;
            aluSll:   result = opA << shamt;
            aluSlt:   result = {31'b0, $signed(opA) < $signed(opB)};
            aluSltu:  result = {31'b0, opA < opB};
            aluXor:   result = opA ^ opB;
            aluSrl:   result = opA >> shamt;
            aluSra:   result = $signed(opA) >>> shamt;
            aluOr:    result = opA | opB;
            aluAnd:   result = opA & opB;
            aluPassB: result = opB;
            default:  result = '0;
        endcase
    end

    // the ID/EX register must only ever carry decoder encodings
    always_comb begin
        assert (aluOp inside {aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
                              aluSrl, aluSra, aluOr, aluAnd, aluPassB})
            else $error("alu: undefined aluOp %0d", aluOp);
    end

endmodule

`default_nettype wire

//--- design/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop import rvPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    output logic [31:0] imemAddr,
    input  logic [31:0] imemData,
    output logic        wbEn,
    output logic [4:0]  wbRd,
    output logic [31:0] wbData
);

    logic [31:0] pc;
    logic [31:0] ifIdInstr, ifIdPc;
    // decode outputs
    logic        decRegWrite, decMemRead, decMemWrite, decMemToReg;
    logic        decBranch, decJump, decJalr, decBSrcImm;
    aSrcT        decASrc;
    aluOpT       decAluOp;
    logic [31:0] decImm, rs1Data, rs2Data;
    // ID/EX
    logic        idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg;
    logic        idExBranch, idExJump, idExJalr, idExBSrcImm;
    aSrcT        idExASrc;
    aluOpT       idExAluOp;
    logic [31:0] idExPc, idExRs1Val, idExRs2Val, idExImm;
    logic [4:0]  idExRs1, idExRs2, idExRd;
    logic [2:0]  idExFunct3;
    // execute
    fwdSelT      fwdA, fwdB;
    logic        stall, flush, brCond, redirect;
    logic [31:0] aluResult, fwdRs1, fwdRs2, brTarget, exResult;
    // EX/MEM and MEM/WB
    logic        exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg;
    logic [31:0] exMemResult, exMemStoreData, memRdata;
    logic [4:0]  exMemRd;
    logic [2:0]  exMemFunct3;
    logic        memWbRegWrite, memWbMemToReg;
    logic [31:0] memWbResult, memWbLoadData;
    logic [4:0]  memWbRd;

    assign imemAddr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (flush) begin
            pc <= brTarget;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            ifIdInstr <= nopInstr;
        end else if (!stall) begin
            ifIdInstr <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifIdPc <= pc;
        end
    end

    decoder decoder_i (
        .instr(ifIdInstr), .regWrite(decRegWrite), .memRead(decMemRead),
        .memWrite(decMemWrite), .memToReg(decMemToReg), .branch(decBranch),
        .jump(decJump), .jalr(decJalr), .bSrcImm(decBSrcImm), .aSrc(decASrc),
        .aluOp(decAluOp), .imm(decImm)
    );

    regFile regFile_i (
        .clk(clk), .rstN(rstN), .rs1Addr(ifIdInstr[19:15]), .rs2Addr(ifIdInstr[24:20]),
        .rdAddr(memWbRd), .we(memWbRegWrite), .rdData(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    // stall leaves a bubble behind the load
    always_ff @(posedge clk) begin
        if (!rstN || flush || stall) begin
            {idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg} <= '0;
            {idExBranch, idExJump, idExJalr, idExBSrcImm} <= '0;
            idExASrc  <= aSrcReg;
            idExAluOp <= aluAdd;
        end else begin
            {idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg} <=
                {decRegWrite, decMemRead, decMemWrite, decMemToReg};
            {idExBranch, idExJump, idExJalr, idExBSrcImm} <=
                {decBranch, decJump, decJalr, decBSrcImm};
            idExASrc  <= decASrc;
            idExAluOp <= decAluOp;
        end
    end

    always_ff @(posedge clk) begin
        idExPc     <= ifIdPc;
        idExRs1Val <= rs1Data;
        idExRs2Val <= rs2Data;
        idExImm    <= decImm;
        idExRs1    <= ifIdInstr[19:15];
        idExRs2    <= ifIdInstr[24:20];
        idExRd     <= ifIdInstr[11:7];
        idExFunct3 <= ifIdInstr[14:12];
    end

    hazardUnit hazardUnit_i (
        .idRs1(ifIdInstr[19:15]), .idRs2(ifIdInstr[24:20]), .exRs1(idExRs1),
        .exRs2(idExRs2), .exRd(idExRd), .memRd(exMemRd), .wbRd(memWbRd),
        .exMemRead(idExMemRead), .memRegWrite(exMemRegWrite), .wbRegWrite(memWbRegWrite),
        .redirect(redirect), .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
    );

    alu alu_i (
        .rs1Val(idExRs1Val), .rs2Val(idExRs2Val), .memFwd(exMemResult), .wbFwd(wbData),
        .pc(idExPc), .imm(idExImm), .fwdA(fwdA), .fwdB(fwdB), .aSrc(idExASrc),
        .bSrcImm(idExBSrcImm), .aluOp(idExAluOp), .result(aluResult),
        .fwdRs1(fwdRs1), .fwdRs2(fwdRs2)
    );

    always_comb begin
        case (idExFunct3)
            3'b000:  brCond = fwdRs1 == fwdRs2;
            3'b001:  brCond = fwdRs1 != fwdRs2;
            3'b100:  brCond = $signed(fwdRs1) < $signed(fwdRs2);
            3'b101:  brCond = $signed(fwdRs1) >= $signed(fwdRs2);
            3'b110:  brCond = fwdRs1 < fwdRs2;
            3'b111:  brCond = fwdRs1 >= fwdRs2;
            default: brCond = 1'b0;
        endcase
    end

    // not-taken is the static guess, so only a taken branch redirects
    assign redirect = (idExBranch && brCond) || idExJump;
    assign brTarget = idExJalr ? ((fwdRs1 + idExImm) & ~32'd1) : idExPc + idExImm;
    assign exResult = idExJump ? idExPc + 32'd4 : aluResult;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            {exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg} <= '0;
            {memWbRegWrite, memWbMemToReg} <= '0;
        end else begin
            {exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg} <=
                {idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg};
            {memWbRegWrite, memWbMemToReg} <= {exMemRegWrite, exMemMemToReg};
        end
    end

    always_ff @(posedge clk) begin
        exMemResult    <= exResult;
        exMemStoreData <= fwdRs2;
        exMemRd        <= idExRd;
        exMemFunct3    <= idExFunct3;
        memWbResult    <= exMemResult;
        memWbLoadData  <= memRdata;
        memWbRd        <= exMemRd;
    end

    dataMem dataMem_i (
        .clk(clk), .memRead(exMemMemRead), .memWrite(exMemMemWrite), .funct3(exMemFunct3),
        .addr(exMemResult), .wdata(exMemStoreData), .rdata(memRdata)
    );

    assign wbData = memWbMemToReg ? memWbLoadData : memWbResult;
    assign wbEn   = memWbRegWrite;
    assign wbRd   = memWbRd;

endmodule

`default_nettype wire

//--- design/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem import rvPkg::*; (
    input  logic        clk,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic [2:0]  funct3,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    logic [31:0] mem [dmemWords];
    logic [$clog2(dmemWords)-1:0] wordIdx;
    logic [3:0]  byteEn;
    logic [31:0] wrWord;
    logic [31:0] rdWord;
    logic [31:0] shifted;
    logic [31:0] loadVal;

    assign wordIdx = addr[$clog2(dmemWords)+1:2];

    // sub-word stores replicate the data across the word
    always_comb begin
        byteEn = 4'b1111;
        wrWord = wdata;
        case (funct3[1:0])
            2'b00: begin
                byteEn = 4'b0001 << addr[1:0];
                wrWord = {4{wdata[7:0]}};
            end
            2'b01: begin
                byteEn = addr[1] ? 4'b1100 : 4'b0011;
                wrWord = {2{wdata[15:0]}};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (memWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    mem[wordIdx][8*b +: 8] <= wrWord[8*b +: 8];
                end
            end
        end
    end

    assign rdWord  = mem[wordIdx];
    assign shifted = rdWord >> {addr[1:0], 3'b000};

    always_comb begin
        case (funct3)
            3'b000:  loadVal = {{24{shifted[7]}}, shifted[7:0]};
            3'b001:  loadVal = {{16{shifted[15]}}, shifted[15:0]};
            3'b100:  loadVal = {24'b0, shifted[7:0]};
            3'b101:  loadVal = {16'b0, shifted[15:0]};
            default: loadVal = rdWord;
        endcase
    end

    assign rdata = memRead ? loadVal : '0;

    alignedAccess: assert property (@(posedge clk)
        (memRead || memWrite) |->
            (funct3[1:0] == 2'b00) || (funct3[1:0] == 2'b01 && !addr[0]) ||
            (addr[1:0] == 2'b00))
        else $error("dataMem: misaligned access at %h", addr);

endmodule

`default_nettype wire

//--- design/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder import rvPkg::*; (
    input  logic [31:0] instr,
    output logic        regWrite,
    output logic        memRead,
    output logic        memWrite,
    output logic        memToReg,
    output logic        branch,
    output logic        jump,
    output logic        jalr,
    output logic        bSrcImm,
    output aSrcT        aSrc,
    output aluOpT       aluOp,
    output logic [31:0] imm
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        altOp;
    logic        writesRd;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    function automatic aluOpT functOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign altOp  = instr[30];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        writesRd = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        branch   = 1'b0;
        jump     = 1'b0;
        jalr     = 1'b0;
        bSrcImm  = 1'b0;
        aSrc     = aSrcReg;
        aluOp    = aluAdd;
        imm      = immI;
        case (opcode)
            opLui: begin
                writesRd = 1'b1;
                aSrc     = aSrcZero;
                bSrcImm  = 1'b1;
                imm      = immU;
            end
            opAuipc: begin
                writesRd = 1'b1;
                aSrc     = aSrcPc;
                bSrcImm  = 1'b1;
                imm      = immU;
            end
            opJal: begin
                writesRd = 1'b1;
                jump     = 1'b1;
                imm      = immJ;
            end
            opJalr: begin
                writesRd = 1'b1;
                jump     = 1'b1;
                jalr     = 1'b1;
            end
            opBranch: begin
                branch = 1'b1;
                aluOp  = aluSub;
                imm    = immB;
            end
            opLoad: begin
                writesRd = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                bSrcImm  = 1'b1;
            end
            opStore: begin
                memWrite = 1'b1;
                bSrcImm  = 1'b1;
                imm      = immS;
            end
            opImm: begin
                writesRd = 1'b1;
                bSrcImm  = 1'b1;
                // funct7 only matters for the right shift here
                aluOp    = functOp(funct3, altOp && funct3 == 3'b101);
            end
            opReg: begin
                writesRd = 1'b1;
                aluOp    = functOp(funct3, altOp);
            end
            default: begin
            end
        endcase
    end

    assign regWrite = writesRd && (instr[11:7] != 5'd0);

endmodule

`default_nettype wire

//--- design/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import rvPkg::*; (
    input  logic [4:0] idRs1,
    input  logic [4:0] idRs2,
    input  logic [4:0] exRs1,
    input  logic [4:0] exRs2,
    input  logic [4:0] exRd,
    input  logic [4:0] memRd,
    input  logic [4:0] wbRd,
    input  logic       exMemRead,
    input  logic       memRegWrite,
    input  logic       wbRegWrite,
    input  logic       redirect,
    output fwdSelT     fwdA,
    output fwdSelT     fwdB,
    output logic       stall,
    output logic       flush
);

    logic loadUse;

    // nearest producer wins
    function automatic fwdSelT pickFwd(input logic [4:0] rs, input logic [4:0] mRd,
                                       input logic mWe, input logic [4:0] wRd,
                                       input logic wWe);
        if (mWe && mRd == rs) begin
            return fwdMem;
        end else if (wWe && wRd == rs) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    assign fwdA = pickFwd(exRs1, memRd, memRegWrite, wbRd, wbRegWrite);
    assign fwdB = pickFwd(exRs2, memRd, memRegWrite, wbRd, wbRegWrite);

    assign loadUse = exMemRead && (exRd == idRs1 || exRd == idRs2);

    assign stall = loadUse;
    assign flush = redirect;

    // a load and a redirect never share the execute stage
    always_comb begin
        assert (!(stall && flush))
            else $error("hazardUnit: stall and flush raised together");
    end

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import rvPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  logic [4:0]  rdAddr,
    input  logic        we,
    input  logic [31:0] rdData,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rdAddr] <= rdData;
        end
    end

    // write-through so writeback and decode can share a cycle
    assign rs1Data = (rs1Addr == 5'd0) ? '0 :
                     (we && rdAddr == rs1Addr) ? rdData : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 :
                     (we && rdAddr == rs2Addr) ? rdData : regs[rs2Addr];

    // decoder is expected to drop regWrite for rd == x0
    weNotX0: assert property (@(posedge clk) disable iff (!rstN) we |-> rdAddr != 5'd0)
        else $error("regFile: write to x0 reached writeback");

endmodule

`default_nettype wire

//--- flist.f
common/rvPkg.sv
design/regFile.sv
design/decoder.sv
design/alu.sv
design/hazardUnit.sv
design/dataMem.sv
design/cpuTop.sv
bench/cpuTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f --top-module cpuTb -o cpuSim &&
{ ./obj_dir/cpuSim > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q "^TESTS PASSED$" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
